// ==== compile.f ====
memPkg.sv
lsqPkg.sv
storeQueue.sv
loadQueueLastSt.sv
loadDisambig.sv
dataMemPort.sv
loadExecPath.sv
tb_loadExecPath.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the load execution path

VERILATOR ?= verilator
TOP       ?= tb_loadExecPath
RTL_TOP   ?= loadExecPath
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_loadExecPath.sv ====
// load execution path testbench
// drives stores, dispatches, loads, commits and flushes into the DUT,
// keeps its own model of queue and memory, checks every cycle
`timescale 1ns/1ps
`default_nettype none

module tb_loadExecPath;

	localparam int ClkPeriod     = 40;
	localparam int CommitTimeout = 20;
	localparam logic [31:0] Seed = 32'he128fb89;

	// expected DUT outputs for one cycle
	typedef struct packed
	{
		logic        dataValid;
		logic [31:0] data;
		logic        vio;
		logic [7:0]  seqNo;
		logic        stall;
	} refOut_t;

	logic                         clk;
	logic                         reset;
	logic                         recover;
	lsqPkg::ldPacket_t            ldPacket;
	lsqPkg::stPacket_t            stPacket;
	lsqPkg::ldDispatch_t          dispatchLd;
	logic                         commitLd;
	lsqPkg::ldqIdx_t              commitLdIdx;
	logic                         commitSt;
	lsqPkg::stqIdx_t              stqHead;
	lsqPkg::stqIdx_t              stqTail;
	lsqPkg::stqCount_t            stqCount;
	logic [memPkg::DataWidth-1:0] loadData;
	logic                         loadDataValid;
	lsqPkg::ldVio_t               ldVio;
	logic                         stallCommit;

	// reference model state
	logic [31:0]        refMem [memPkg::MemWords];
	memPkg::memAddr_u   sqAddr [lsqPkg::StqDepth];
	memPkg::ldstSize_t  sqSize [lsqPkg::StqDepth];
	logic [31:0]        sqData [lsqPkg::StqDepth];
	logic               sqValid [lsqPkg::StqDepth];
	lsqPkg::stqIdx_t    ldLastSt [lsqPkg::LdqDepth];
	logic               ldLastStValid [lsqPkg::LdqDepth];
	logic [7:0]         seqCounter;

	loadExecPath u_dut (
		.clk(clk), .reset(reset), .recover_i(recover),
		.ldPacket_i(ldPacket), .stPacket_i(stPacket), .dispatchLd_i(dispatchLd),
		.commitLd_i(commitLd), .commitLdIdx_i(commitLdIdx), .commitSt_i(commitSt),
		.stqHead_i(stqHead), .stqTail_i(stqTail), .stqCount_i(stqCount),
		.loadData_o(loadData), .loadDataValid_o(loadDataValid),
		.ldVio_o(ldVio), .stallCommit_o(stallCommit)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic int sizeBytes(memPkg::ldstSize_t size);
		case (size)
			memPkg::sizeByte: return 1;
			memPkg::sizeHalf: return 2;
			default:          return 4;
		endcase
	endfunction

	// expected outputs from the queue and memory model
	function automatic refOut_t expectedOutputs(lsqPkg::ldPacket_t ld, logic commitReq);
		refOut_t         r;
		logic [31:0]     raw;
		lsqPkg::stqIdx_t idx;
		int              span;
		logic            partial;
		span = -1;
		partial = 1'b0;
		raw = refMem[ld.addr.word.wordIdx] >> (8 * ld.addr.word.byteOff);
		// lastSt only counts when it is one of the occupied slots
		if (ldLastStValid[ld.ldqId])
		begin
			for (int k = 0; k < int'(stqCount); k++)
			begin
				if (span < 0 && lsqPkg::stqIdx_t'(stqHead + k) == ldLastSt[ld.ldqId])
					span = k;
			end
		end
		// oldest first, a later full match replaces an earlier one
		for (int k = 0; k <= span; k++)
		begin
			idx = lsqPkg::stqIdx_t'(stqHead + k);
			if (sqValid[idx] && sqAddr[idx].word.wordIdx == ld.addr.word.wordIdx)
			begin
				if (sqAddr[idx].word.byteOff == ld.addr.word.byteOff && sqSize[idx] >= ld.size)
					raw = sqData[idx];
				else
					partial = 1'b1;
			end
		end
		r.dataValid = ld.valid;
		r.vio = ld.valid && partial;
		r.seqNo = ld.seqNo;
		r.stall = commitReq && ld.valid;
		case (ld.size)
			memPkg::sizeByte: r.data = ld.sign ? {{24{raw[7]}}, raw[7:0]} : {24'h0, raw[7:0]};
			memPkg::sizeHalf: r.data = ld.sign ? {{16{raw[15]}}, raw[15:0]} : {16'h0, raw[15:0]};
			default:          r.data = raw;
		endcase
		return r;
	endfunction

	task automatic expectEqual(string name, logic [31:0] actual, logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAILED %s: actual 0x%08h, expected 0x%08h", name, actual, expected);
			$display("Simulation FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic failRun(string what);
		$display("ERROR: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic compareOutputs();
		refOut_t e;
		e = expectedOutputs(ldPacket, commitSt);
		expectEqual("loadDataValid_o", 32'(loadDataValid), 32'(e.dataValid));
		expectEqual("ldVio_o.valid", 32'(ldVio.valid), 32'(e.vio));
		expectEqual("stallCommit_o", 32'(stallCommit), 32'(e.stall));
		if (e.dataValid)
			expectEqual("loadData_o", loadData, e.data);
		if (e.vio)
			expectEqual("ldVio_o.seqNo", 32'(ldVio.seqNo), 32'(e.seqNo));
	endtask

	// effect of the coming rising edge on the model
	task automatic modelClockEdge();
		logic             taken;
		memPkg::memAddr_u a;
		int               pos;
		taken = commitSt && !ldPacket.valid;
		if (taken)
		begin
			a = sqAddr[stqHead];
			for (int b = 0; b < sizeBytes(sqSize[stqHead]); b++)
			begin
				pos = a.word.byteOff + b;
				if (pos < 4)
					refMem[a.word.wordIdx][pos*8 +: 8] = sqData[stqHead][b*8 +: 8];
			end
		end
		if (recover)
		begin
			for (int i = 0; i < lsqPkg::StqDepth; i++)
				sqValid[i] = 1'b0;
			for (int i = 0; i < lsqPkg::LdqDepth; i++)
				ldLastStValid[i] = 1'b0;
		end
		else
		begin
			if (taken)
			begin
				sqValid[stqHead] = 1'b0;
				for (int i = 0; i < lsqPkg::LdqDepth; i++)
				begin
					if (ldLastSt[i] == stqHead)
						ldLastStValid[i] = 1'b0;
				end
			end
			if (stPacket.valid)
			begin
				sqAddr[stPacket.stqId] = stPacket.addr;
				sqSize[stPacket.stqId] = stPacket.size;
				sqData[stPacket.stqId] = stPacket.data;
				sqValid[stPacket.stqId] = 1'b1;
			end
			if (commitLd)
				ldLastStValid[commitLdIdx] = 1'b0;
			if (dispatchLd.valid)
			begin
				ldLastSt[dispatchLd.ldqId] = dispatchLd.lastSt;
				ldLastStValid[dispatchLd.ldqId] = !dispatchLd.stqEmpty &&
					!(taken && dispatchLd.lastSt == stqHead);
			end
		end
	endtask

	// sample just before each rising edge
	always
	begin
		@(posedge clk);
		#(ClkPeriod - 3);
		if (!reset)
		begin
			compareOutputs();
			modelClockEdge();
		end
	end

	task automatic clearStrobes();
		ldPacket = '0;
		stPacket = '0;
		dispatchLd = '0;
		commitLd = 1'b0;
		commitLdIdx = '0;
		commitSt = 1'b0;
		recover = 1'b0;
	endtask

	// inputs change 2 ns after the edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
		clearStrobes();
	endtask

	function automatic lsqPkg::ldPacket_t makeLoad(lsqPkg::ldqIdx_t id, logic [7:0] addr,
		memPkg::ldstSize_t size, logic sign, logic [7:0] seqNo);
		lsqPkg::ldPacket_t ld;
		ld.valid = 1'b1;
		ld.ldqId = id;
		ld.addr.flat = addr;
		ld.size = size;
		ld.sign = sign;
		ld.seqNo = seqNo;
		return ld;
	endfunction

	task automatic issueStore(logic [7:0] addr, memPkg::ldstSize_t size, logic [31:0] data);
		stPacket.valid = 1'b1;
		stPacket.stqId = stqTail;
		stPacket.addr.flat = addr;
		stPacket.size = size;
		stPacket.data = data;
		nextCycle();
		stqTail = stqTail + 1'b1;
		stqCount = stqCount + 1'b1;
	endtask

	task automatic issueLoad(lsqPkg::ldqIdx_t id, logic [7:0] addr,
		memPkg::ldstSize_t size, logic sign);
		ldPacket = makeLoad(id, addr, size, sign, seqCounter);
		seqCounter = seqCounter + 1'b1;
		nextCycle();
	endtask

	// youngest store so far is the load's last older store
	task automatic dispatchLoad(lsqPkg::ldqIdx_t id);
		dispatchLd.valid = 1'b1;
		dispatchLd.ldqId = id;
		dispatchLd.lastSt = stqTail - 1'b1;
		dispatchLd.stqEmpty = (stqCount == 0);
		nextCycle();
	endtask

	task automatic retireLoad(lsqPkg::ldqIdx_t id);
		commitLd = 1'b1;
		commitLdIdx = id;
		nextCycle();
	endtask

	// hold the commit request until the port stops stalling it
	task automatic commitHead(lsqPkg::ldPacket_t ld, output int cycles);
		logic taken;
		taken = 1'b0;
		cycles = 0;
		ldPacket = ld;
		while (!taken && cycles < CommitTimeout)
		begin
			commitSt = 1'b1;
			// stall level sampled 2 ns before the edge
			#(ClkPeriod - 4);
			taken = !stallCommit;
			@(posedge clk);
			cycles++;
			#2;
			clearStrobes();
		end
		if (!taken)
			failRun("store commit was never accepted by the memory port");
		else
		begin
			stqHead = stqHead + 1'b1;
			stqCount = stqCount - 1'b1;
		end
	endtask

	task automatic drainStores();
		int cycles;
		for (int i = 0; i < lsqPkg::StqDepth && stqCount != 0; i++)
			commitHead('0, cycles);
	endtask

	function automatic logic [7:0] alignedAddr(memPkg::ldstSize_t size);
		logic [7:0] a;
		a = 8'($urandom_range(255, 0));
		if (size == memPkg::sizeHalf)
			a[0] = 1'b0;
		else if (size == memPkg::sizeWord)
			a[1:0] = 2'b00;
		return a;
	endfunction

	// every word first, then sub-word writes on top
	task automatic fillMemory();
		int                cycles;
		memPkg::ldstSize_t size;
		for (int w = 0; w < memPkg::MemWords; w++)
		begin
			issueStore(8'(w * 4), memPkg::sizeWord, $urandom ^ (32'(w) * 32'h01010101));
			commitHead('0, cycles);
		end
		for (int i = 0; i < 16; i++)
		begin
			size = memPkg::ldstSize_t'($urandom_range(2, 0));
			issueStore(alignedAddr(size), size, $urandom);
			commitHead('0, cycles);
		end
	endtask

	task automatic randomLoads(int count);
		memPkg::ldstSize_t size;
		for (int i = 0; i < count; i++)
		begin
			size = memPkg::ldstSize_t'($urandom_range(2, 0));
			issueLoad(3'($urandom_range(7, 0)), alignedAddr(size), size, 1'($urandom_range(1, 0)));
		end
	endtask

	task automatic forwardFromStore();
		issueStore(8'h20, memPkg::sizeWord, ~refMem[8]);
		dispatchLoad(1);
		issueLoad(1, 8'h20, memPkg::sizeWord, 1'b0);
		issueLoad(1, 8'h20, memPkg::sizeHalf, 1'b1);
		issueLoad(1, 8'h20, memPkg::sizeByte, 1'b0);
		drainStores();
		retireLoad(1);
	endtask

	// window wraps past the last slot, a younger store follows the load
	task automatic youngestInWindow();
		int cycles;
		for (int i = 0; i < lsqPkg::StqDepth; i++)
		begin
			if (stqTail != 3'd6)
			begin
				issueStore(alignedAddr(memPkg::sizeWord), memPkg::sizeWord, $urandom);
				commitHead('0, cycles);
			end
		end
		issueStore(8'h44, memPkg::sizeWord, $urandom);
		issueStore(8'h44, memPkg::sizeWord, $urandom);
		issueStore(8'h44, memPkg::sizeWord, ~refMem[17]);
		dispatchLoad(2);
		issueStore(8'h44, memPkg::sizeWord, $urandom);
		issueLoad(2, 8'h44, memPkg::sizeWord, 1'b0);
		issueLoad(2, 8'h44, memPkg::sizeByte, 1'b1);
		drainStores();
		retireLoad(2);
	endtask

	task automatic partialOverlap();
		// upper half only, load reads from offset 0
		issueStore(8'h62, memPkg::sizeHalf, $urandom);
		dispatchLoad(3);
		issueLoad(3, 8'h60, memPkg::sizeWord, 1'b0);
		// byte store under a half load
		issueStore(8'h70, memPkg::sizeByte, $urandom);
		dispatchLoad(4);
		issueLoad(4, 8'h70, memPkg::sizeHalf, 1'b1);
		issueLoad(4, 8'h70, memPkg::sizeByte, 1'b1);
		drainStores();
		retireLoad(3);
		retireLoad(4);
	endtask

	task automatic commitUnderLoad();
		int cycles;
		issueStore(8'h84, memPkg::sizeWord, ~refMem[33]);
		dispatchLoad(5);
		commitHead(makeLoad(5, 8'h84, memPkg::sizeWord, 1'b0, seqCounter), cycles);
		seqCounter = seqCounter + 1'b1;
		if (cycles < 2)
			failRun("store commit was not held back by the load in the same cycle");
		// last store gone, the load now reads the written word
		issueLoad(5, 8'h84, memPkg::sizeWord, 1'b0);
		issueLoad(5, 8'h86, memPkg::sizeHalf, 1'b1);
		retireLoad(5);
	endtask

	task automatic flushQueues();
		issueStore(8'ha0, memPkg::sizeWord, ~refMem[40]);
		dispatchLoad(6);
		issueLoad(6, 8'ha0, memPkg::sizeWord, 1'b0);
		// dispatch during the flush is dropped
		recover = 1'b1;
		dispatchLd.valid = 1'b1;
		dispatchLd.ldqId = 3'd0;
		dispatchLd.lastSt = stqTail - 1'b1;
		dispatchLd.stqEmpty = 1'b0;
		nextCycle();
		issueLoad(6, 8'ha0, memPkg::sizeWord, 1'b0);
		issueLoad(0, 8'ha0, memPkg::sizeWord, 1'b0);
		// window still covers the squashed slot, its address is gone
		dispatchLoad(7);
		issueLoad(7, 8'ha0, memPkg::sizeWord, 1'b0);
		stqTail = stqHead;
		stqCount = '0;
		retireLoad(6);
		retireLoad(7);
	endtask

	initial
	begin
		void'($urandom(Seed));
		clk = 1'b0;
		reset = 1'b1;
		clearStrobes();
		stqHead = '0;
		stqTail = '0;
		stqCount = '0;
		seqCounter = '0;
		for (int i = 0; i < lsqPkg::StqDepth; i++)
			sqValid[i] = 1'b0;
		for (int i = 0; i < lsqPkg::LdqDepth; i++)
		begin
			ldLastSt[i] = '0;
			ldLastStValid[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		// idle cycles check the quiet outputs
		repeat (3) nextCycle();
		fillMemory();
		randomLoads(40);
		forwardFromStore();
		youngestInWindow();
		partialOverlap();
		commitUnderLoad();
		flushQueues();
		randomLoads(12);
		nextCycle();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== loadExecPath.sv ====
// load execution path
// store queue, last-store table, disambiguation and the data memory port
`timescale 1ns/1ps
`default_nettype none

module loadExecPath
(
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            recover_i,
	input  wire lsqPkg::ldPacket_t         ldPacket_i,
	input  wire lsqPkg::stPacket_t         stPacket_i,
	input  wire lsqPkg::ldDispatch_t       dispatchLd_i,
	input  wire                            commitLd_i,
	input  wire lsqPkg::ldqIdx_t           commitLdIdx_i,
	input  wire                            commitSt_i,
	input  wire lsqPkg::stqIdx_t           stqHead_i,
	input  wire lsqPkg::stqIdx_t           stqTail_i,
	input  wire lsqPkg::stqCount_t         stqCount_i,
	output logic [memPkg::DataWidth-1:0]   loadData_o,
	output logic                           loadDataValid_o,
	output lsqPkg::ldVio_t                 ldVio_o,
	output logic                           stallCommit_o
);

	// store queue to disambiguation
	logic [lsqPkg::StqDepth-1:0]   wordMatch;
	logic [lsqPkg::StqDepth-1:0]   offMatch;
	logic [lsqPkg::StqDepth-1:0]   sizeShort;
	logic [lsqPkg::StqDepth-1:0]   addrValid;
	logic [memPkg::DataWidth-1:0]  fwdData;
	lsqPkg::stqIdx_t               fwdIdx;
	// head entry to the memory port
	memPkg::memAddr_u              headAddr;
	memPkg::ldstSize_t             headSize;
	logic [memPkg::DataWidth-1:0]  headData;
	// last-store lookup and memory read
	lsqPkg::stqIdx_t               lastSt;
	logic                          lastStValid;
	logic [memPkg::DataWidth-1:0]  memData;
	logic                          commitTaken;

	storeQueue u_storeQueue (
		.clk(clk), .reset(reset), .recover_i(recover_i),
		.stPacket_i(stPacket_i), .ldPacket_i(ldPacket_i), .stqHead_i(stqHead_i),
		.commitTaken_i(commitTaken), .fwdIdx_i(fwdIdx),
		.wordMatch_o(wordMatch), .offMatch_o(offMatch), .sizeShort_o(sizeShort),
		.addrValid_o(addrValid), .headAddr_o(headAddr), .headSize_o(headSize),
		.headData_o(headData), .fwdData_o(fwdData)
	);

	loadQueueLastSt u_loadQueueLastSt (
		.clk(clk), .reset(reset), .recover_i(recover_i),
		.dispatchLd_i(dispatchLd_i), .commitLd_i(commitLd_i),
		.commitLdIdx_i(commitLdIdx_i), .commitTaken_i(commitTaken),
		.stqHead_i(stqHead_i), .ldqId_i(ldPacket_i.ldqId),
		.lastSt_o(lastSt), .lastStValid_o(lastStValid)
	);

	loadDisambig u_loadDisambig (
		.ldPacket_i(ldPacket_i), .stqHead_i(stqHead_i), .stqTail_i(stqTail_i),
		.stqCount_i(stqCount_i), .lastSt_i(lastSt), .lastStValid_i(lastStValid),
		.wordMatch_i(wordMatch), .offMatch_i(offMatch), .sizeShort_i(sizeShort),
		.addrValid_i(addrValid), .fwdData_i(fwdData), .memData_i(memData),
		.fwdIdx_o(fwdIdx), .loadData_o(loadData_o),
		.loadDataValid_o(loadDataValid_o), .ldVio_o(ldVio_o)
	);

	dataMemPort u_dataMemPort (
		.clk(clk), .reset(reset), .ldPacket_i(ldPacket_i), .commitSt_i(commitSt_i),
		.headAddr_i(headAddr), .headSize_i(headSize), .headData_i(headData),
		.memData_o(memData), .commitTaken_o(commitTaken), .stallCommit_o(stallCommit_o)
	);

endmodule

`default_nettype wire

// ==== dataMemPort.sv ====
// data memory port
// one shared port, the load read wins over the store commit write,
// byte-enable writes and offset-aligned reads
`timescale 1ns/1ps
`default_nettype none

module dataMemPort
(
	input  wire                                clk,
	input  wire                                reset,
	input  wire lsqPkg::ldPacket_t             ldPacket_i,
	input  wire                                commitSt_i,
	input  wire memPkg::memAddr_u              headAddr_i,
	input  wire memPkg::ldstSize_t             headSize_i,
	input  wire [memPkg::DataWidth-1:0]        headData_i,
	output logic [memPkg::DataWidth-1:0]       memData_o,
	output logic                               commitTaken_o,
	output logic                               stallCommit_o
);

	logic [memPkg::DataWidth-1:0] mem [memPkg::MemWords];

	logic [memPkg::DataBytes-1:0] sizeMask;
	logic [memPkg::DataBytes-1:0] byteEn;
	logic [memPkg::DataWidth-1:0] wrData;
	logic [memPkg::DataWidth-1:0] rdWord;
	// store lanes over two words, upper half is past the word end
	logic [2*memPkg::DataBytes-1:0] laneSpan;

	// arbiter, a valid load owns the port this cycle
	assign stallCommit_o = commitSt_i && ldPacket_i.valid;
	assign commitTaken_o = commitSt_i && !ldPacket_i.valid;

	// bytes covered by the store size
	always_comb
	begin
		case (headSize_i)
			memPkg::sizeByte: sizeMask = 4'b0001;
			memPkg::sizeHalf: sizeMask = 4'b0011;
			default:          sizeMask = 4'b1111;
		endcase
	end

	// lanes and data moved up to the byte offset
	// bytes past the word end are dropped, stores are expected aligned
	assign byteEn = sizeMask << headAddr_i.word.byteOff;
	assign wrData = headData_i << {headAddr_i.word.byteOff, 3'b000};

	assign laneSpan = {{memPkg::DataBytes{1'b0}}, sizeMask} << headAddr_i.word.byteOff;

	always_ff @(posedge clk)
	begin
		if (commitTaken_o)
		begin
			for (int b = 0; b < memPkg::DataBytes; b++)
			begin
				if (byteEn[b])
				begin
					mem[headAddr_i.word.wordIdx][b*8 +: 8] <= wrData[b*8 +: 8];
				end
			end
		end
	end

	// asynchronous read, addressed byte lands in the low lane
	assign rdWord    = mem[ldPacket_i.addr.word.wordIdx];
	assign memData_o = rdWord >> {ldPacket_i.addr.word.byteOff, 3'b000};

	// a written store must fit inside its data word
	commitInWord: assert property (@(posedge clk) disable iff (reset)
		commitTaken_o |-> (laneSpan[2*memPkg::DataBytes-1:memPkg::DataBytes] == '0))
		else $error("store commit reaches past the end of its data word");

endmodule

`default_nettype wire

// ==== loadDisambig.sv ====
// load disambiguation
// finds older stores in the load's window, picks the youngest full match
// for forwarding, flags partial overlaps and formats the load result
`timescale 1ns/1ps
`default_nettype none

module loadDisambig
(
	input  wire lsqPkg::ldPacket_t               ldPacket_i,
	input  wire lsqPkg::stqIdx_t                 stqHead_i,
	input  wire lsqPkg::stqIdx_t                 stqTail_i,
	input  wire lsqPkg::stqCount_t               stqCount_i,
	input  wire lsqPkg::stqIdx_t                 lastSt_i,
	input  wire                                  lastStValid_i,
	input  wire [lsqPkg::StqDepth-1:0]           wordMatch_i,
	input  wire [lsqPkg::StqDepth-1:0]           offMatch_i,
	input  wire [lsqPkg::StqDepth-1:0]           sizeShort_i,
	input  wire [lsqPkg::StqDepth-1:0]           addrValid_i,
	input  wire [memPkg::DataWidth-1:0]          fwdData_i,
	input  wire [memPkg::DataWidth-1:0]          memData_i,
	output lsqPkg::stqIdx_t                      fwdIdx_o,
	output logic [memPkg::DataWidth-1:0]         loadData_o,
	output logic                                 loadDataValid_o,
	output lsqPkg::ldVio_t                       ldVio_o
);

	logic                          lastStInQueue;
	logic                          stqWrap;
	logic [lsqPkg::StqDepth-1:0]   window;
	logic [lsqPkg::StqDepth-1:0]   fullVec;
	logic [lsqPkg::StqDepth-1:0]   partVec;
	logic                          stqHit;
	logic [memPkg::DataWidth-1:0]  rawData;

	// lastSt must sit between head and tail, full queue has head == tail
	always_comb
	begin
		if (stqCount_i == '0)
			lastStInQueue = 1'b0;
		else if (stqHead_i < stqTail_i)
			lastStInQueue = (lastSt_i >= stqHead_i) && (lastSt_i < stqTail_i);
		else
			lastStInQueue = (lastSt_i >= stqHead_i) || (lastSt_i < stqTail_i);
	end

	assign stqWrap = (stqHead_i > lastSt_i);

	// stores from head up to lastSt are older than the load
	always_comb
	begin
		lsqPkg::stqIdx_t idx;
		for (int i = 0; i < lsqPkg::StqDepth; i++)
		begin
			idx = lsqPkg::stqIdx_t'(i);
			if (!(lastStValid_i && lastStInQueue))
				window[i] = 1'b0;
			else if (stqWrap)
				window[i] = (idx >= stqHead_i) || (idx <= lastSt_i);
			else
				window[i] = (idx >= stqHead_i) && (idx <= lastSt_i);
		end
	end

	// same bytes vs overlapping bytes of a different shape
	assign fullVec = addrValid_i & window & wordMatch_i & offMatch_i & ~sizeShort_i;
	assign partVec = addrValid_i & window & wordMatch_i & (~offMatch_i | sizeShort_i);

	// oldest to youngest, last hit is the youngest
	always_comb
	begin
		lsqPkg::stqIdx_t idx;
		stqHit   = 1'b0;
		fwdIdx_o = '0;
		for (int k = 0; k < lsqPkg::StqDepth; k++)
		begin
			idx = stqHead_i + lsqPkg::stqIdx_t'(k);
			if (fullVec[idx])
			begin
				stqHit   = 1'b1;
				fwdIdx_o = idx;
			end
		end
	end

	assign ldVio_o.valid   = ldPacket_i.valid && (|partVec);
	assign ldVio_o.seqNo   = ldPacket_i.seqNo;
	assign loadDataValid_o = ldPacket_i.valid;

	// memory word arrives already shifted down by the byte offset
	assign rawData = stqHit ? fwdData_i : memData_i;

	// size truncation then sign or zero extension
	always_comb
	begin
		case (ldPacket_i.size)
			memPkg::sizeByte:
				loadData_o = {{24{ldPacket_i.sign & rawData[7]}}, rawData[7:0]};
			memPkg::sizeHalf:
				loadData_o = {{16{ldPacket_i.sign & rawData[15]}}, rawData[15:0]};
			default:
				loadData_o = rawData;
		endcase
	end

endmodule

`default_nettype wire

// ==== loadQueueLastSt.sv ====
// load queue last-store table
// per load, the youngest older store index and whether that store is
// still waiting in the store queue
`timescale 1ns/1ps
`default_nettype none

module loadQueueLastSt
(
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        recover_i,
	input  wire lsqPkg::ldDispatch_t   dispatchLd_i,
	input  wire                        commitLd_i,
	input  wire lsqPkg::ldqIdx_t       commitLdIdx_i,
	input  wire                        commitTaken_i,
	input  wire lsqPkg::stqIdx_t       stqHead_i,
	input  wire lsqPkg::ldqIdx_t       ldqId_i,
	output lsqPkg::stqIdx_t            lastSt_o,
	output logic                       lastStValid_o
);

	lsqPkg::stqIdx_t              lastStMem [lsqPkg::LdqDepth];
	logic [lsqPkg::LdqDepth-1:0]  lastStValid;
	logic                         dispWrite;
	logic                         dispValid;

	assign dispWrite = dispatchLd_i.valid && !recover_i;

	// a last store that commits in the dispatch cycle is already gone
	assign dispValid = !dispatchLd_i.stqEmpty &&
		!(commitTaken_i && (dispatchLd_i.lastSt == stqHead_i));

	always_ff @(posedge clk)
	begin
		if (dispWrite)
		begin
			lastStMem[dispatchLd_i.ldqId] <= dispatchLd_i.lastSt;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lastStValid <= '0;
		end
		else if (recover_i)
		begin
			lastStValid <= '0;
		end
		else
		begin
			// loads whose last store just left the queue
			for (int i = 0; i < lsqPkg::LdqDepth; i++)
			begin
				if (commitTaken_i && (lastStMem[i] == stqHead_i))
				begin
					lastStValid[i] <= 1'b0;
				end
			end
			// retired load frees its slot
			if (commitLd_i)
			begin
				lastStValid[commitLdIdx_i] <= 1'b0;
			end
			if (dispWrite)
			begin
				lastStValid[dispatchLd_i.ldqId] <= dispValid;
			end
		end
	end

	// lookup for the executing load
	assign lastSt_o      = lastStMem[ldqId_i];
	assign lastStValid_o = lastStValid[ldqId_i];

	// a slot is never allocated and retired in the same cycle
	noDispCommitClash: assert property (@(posedge clk) disable iff (reset)
		(dispatchLd_i.valid && commitLd_i) |-> (dispatchLd_i.ldqId != commitLdIdx_i))
		else $error("load dispatch and load commit on the same queue entry");

endmodule

`default_nettype wire

// ==== storeQueue.sv ====
// store queue
// keeps address, size and data of each store from address generation,
// the address-valid bits, and the per-entry match of the current load
`timescale 1ns/1ps
`default_nettype none

module storeQueue
(
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                recover_i,
	input  wire lsqPkg::stPacket_t             stPacket_i,
	input  wire lsqPkg::ldPacket_t             ldPacket_i,
	input  wire lsqPkg::stqIdx_t               stqHead_i,
	input  wire                                commitTaken_i,
	input  wire lsqPkg::stqIdx_t               fwdIdx_i,
	output logic [lsqPkg::StqDepth-1:0]        wordMatch_o,
	output logic [lsqPkg::StqDepth-1:0]        offMatch_o,
	output logic [lsqPkg::StqDepth-1:0]        sizeShort_o,
	output logic [lsqPkg::StqDepth-1:0]        addrValid_o,
	output memPkg::memAddr_u                   headAddr_o,
	output memPkg::ldstSize_t                  headSize_o,
	output logic [memPkg::DataWidth-1:0]       headData_o,
	output logic [memPkg::DataWidth-1:0]       fwdData_o
);

	// payload arrays
	memPkg::memAddr_u             stqAddr [lsqPkg::StqDepth];
	memPkg::ldstSize_t            stqSize [lsqPkg::StqDepth];
	logic [memPkg::DataWidth-1:0] stqData [lsqPkg::StqDepth];

	logic [lsqPkg::StqDepth-1:0]  stqAddrValid;
	logic                         stWrite;

	// stores arriving during a flush are dropped
	assign stWrite = stPacket_i.valid && !recover_i;

	// payload capture at address generation
	always_ff @(posedge clk)
	begin
		if (stWrite)
		begin
			stqAddr[stPacket_i.stqId] <= stPacket_i.addr;
			stqSize[stPacket_i.stqId] <= stPacket_i.size;
			stqData[stPacket_i.stqId] <= stPacket_i.data;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stqAddrValid <= '0;
		end
		else if (recover_i)
		begin
			// every in-flight store is squashed
			stqAddrValid <= '0;
		end
		else
		begin
			// head leaves once its write is taken
			if (commitTaken_i)
			begin
				stqAddrValid[stqHead_i] <= 1'b0;
			end
			// new store last, so it wins on the same slot
			if (stWrite)
			begin
				stqAddrValid[stPacket_i.stqId] <= 1'b1;
			end
		end
	end

	// content match against the load
	always_comb
	begin
		for (int i = 0; i < lsqPkg::StqDepth; i++)
		begin
			wordMatch_o[i] = (stqAddr[i].word.wordIdx == ldPacket_i.addr.word.wordIdx);
			offMatch_o[i]  = (stqAddr[i].word.byteOff == ldPacket_i.addr.word.byteOff);
			// store writes fewer bytes than the load reads
			sizeShort_o[i] = (stqSize[i] < ldPacket_i.size);
		end
	end

	assign addrValid_o = stqAddrValid;

	// head entry towards the memory port
	assign headAddr_o  = stqAddr[stqHead_i];
	assign headSize_o  = stqSize[stqHead_i];
	assign headData_o  = stqData[stqHead_i];

	// entry picked by the disambiguation logic
	assign fwdData_o   = stqData[fwdIdx_i];

	// memory port must never retire a store whose address never arrived
	commitHasAddr: assert property (@(posedge clk) disable iff (reset)
		commitTaken_i |-> stqAddrValid[stqHead_i])
		else $error("store commit taken on an entry without a valid address");

endmodule

`default_nettype wire

// ==== lsqPkg.sv ====
// load/store queue package
// queue depths, index types and the packets that travel through the load path
`default_nettype none

package lsqPkg;

	localparam int StqDepth = 8;
	localparam int LdqDepth = 8;

	typedef logic [$clog2(StqDepth)-1:0] stqIdx_t;
	typedef logic [$clog2(LdqDepth)-1:0] ldqIdx_t;
	// one extra bit so a full queue is countable
	typedef logic [$clog2(StqDepth):0]   stqCount_t;
	typedef logic [7:0]                  seqNo_t;

	// store from address generation
	typedef struct packed
	{
		logic                          valid;
		stqIdx_t                       stqId;
		memPkg::memAddr_u              addr;
		memPkg::ldstSize_t             size;
		logic [memPkg::DataWidth-1:0]  data;
	} stPacket_t;

	// load from address generation
	typedef struct packed
	{
		logic                 valid;
		ldqIdx_t              ldqId;
		memPkg::memAddr_u     addr;
		memPkg::ldstSize_t    size;
		logic                 sign;
		seqNo_t               seqNo;
	} ldPacket_t;

	// load dispatch, lastSt is the youngest store older than the load
	typedef struct packed
	{
		logic    valid;
		ldqIdx_t ldqId;
		stqIdx_t lastSt;
		// no older store in the queue at dispatch
		logic    stqEmpty;
	} ldDispatch_t;

	typedef struct packed
	{
		logic   valid;
		seqNo_t seqNo;
	} ldVio_t;

endpackage

`default_nettype wire

// ==== memPkg.sv ====
// memory package
// word and address widths, the load/store access size encoding and the
// data address that is read either flat or as word index plus byte offset
`default_nettype none

package memPkg;

	// byte address, one data word
	localparam int AddrWidth    = 8;
	localparam int DataWidth    = 32;
	localparam int OffsetWidth  = 2;
	localparam int DataBytes    = DataWidth / 8;
	localparam int WordIdxWidth = AddrWidth - OffsetWidth;

	// data memory depth in words, one word per index value
	localparam int MemWords     = 64;

	// access size, values match the load/store size field of the core
	typedef enum logic [1:0]
	{
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} ldstSize_t;

	// word index above, byte offset in the low bits
	typedef struct packed
	{
		logic [WordIdxWidth-1:0] wordIdx;
		logic [OffsetWidth-1:0]  byteOff;
	} wordAddr_t;

	// same address bits, two readings
	typedef union packed
	{
		logic [AddrWidth-1:0] flat;
		wordAddr_t            word;
	} memAddr_u;

endpackage

`default_nettype wire
